// ==== kal_num_pkg.sv ====
package kal_num_pkg;

  // datapath width for state, variance, gain and the divider
  localparam int DATA_W = 32;

  // raw sample width from the sensor side
  localparam int MEAS_W = 14;

  // gain and probabilities are Q13
  localparam int FRAC_BITS = 13;
  localparam int ONE_Q13   = 1 << FRAC_BITS;  // 8192 == 1.0

  // variance loaded at reset, estimate starts at zero
  localparam int P_INIT = 100000;

  // queue entries, also the credits the sender owns after reset
  localparam int MEAS_QUEUE_DEPTH = 4;

  // queue pointer and occupancy widths
  localparam int QUEUE_PTR_W = $clog2(MEAS_QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(MEAS_QUEUE_DEPTH + 1);

  // bit counter in the divider, must hold DATA_W itself
  localparam int DIV_CNT_W = $clog2(DATA_W + 1);

  // product width of the update multipliers
  localparam int PROD_W = 2 * DATA_W;

endpackage

// ==== kal_ctrl_pkg.sv ====
package kal_ctrl_pkg;

  // filter sequencing, one pass per popped measurement
  typedef enum logic [2:0] {
    IDLE,         // wait for a queued sample
    PREDICT,      // prior state/variance, launch divide
    GAIN,         // divider running
    UPDATE_WAIT,  // multiplier pipeline fill
    UPDATE        // write estimate, pulse valid
  } kal_state_e;

  // noise config, sampled once per update
  typedef struct packed {
    logic [kal_num_pkg::DATA_W-1:0] q;  // process noise
    logic [kal_num_pkg::DATA_W-1:0] r;  // measurement noise
  } kal_cfg_t;

  typedef struct packed {
    logic signed [kal_num_pkg::MEAS_W-1:0] z;  // raw sample
  } kal_meas_t;

  typedef struct packed {
    logic signed [kal_num_pkg::DATA_W-1:0] x;  // state estimate
    logic signed [kal_num_pkg::DATA_W-1:0] p;  // error variance
  } kal_est_t;

endpackage

// ==== kal_divider.sv ====
`timescale 1ns/1ns

module kal_divider (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_start,
  input  logic [kal_num_pkg::DATA_W-1:0] i_dividend,
  input  logic [kal_num_pkg::DATA_W-1:0] i_divisor,
  output logic                           o_done,
  output logic [kal_num_pkg::DATA_W-1:0] o_quotient
);

  logic [kal_num_pkg::DATA_W-1:0]    rem_q;   // partial remainder
  logic [kal_num_pkg::DATA_W-1:0]    quo_q;   // dividend out the top, quotient in the bottom
  logic [kal_num_pkg::DATA_W-1:0]    dsr_q;   // divisor held for the whole run
  logic [kal_num_pkg::DIV_CNT_W-1:0] cnt_q;   // bits left
  logic                              busy_q;
  logic                              done_q;
  logic [kal_num_pkg::DATA_W:0]      trial;   // remainder with next dividend bit
  logic [kal_num_pkg::DATA_W+1:0]    diff;    // msb set means trial < divisor

  assign trial = {rem_q, quo_q[kal_num_pkg::DATA_W-1]};
  assign diff  = {1'b0, trial} - {2'b00, dsr_q};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rem_q  <= '0;
      quo_q  <= '0;
      dsr_q  <= '0;
      cnt_q  <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;  // single cycle pulse
      if (i_start) begin
        rem_q  <= '0;
        quo_q  <= i_dividend;
        dsr_q  <= i_divisor;
        cnt_q  <= kal_num_pkg::DIV_CNT_W'(kal_num_pkg::DATA_W);
        busy_q <= 1'b1;
      end else if (busy_q) begin
        if (!diff[kal_num_pkg::DATA_W+1]) begin
          rem_q <= diff[kal_num_pkg::DATA_W-1:0];  // subtract fits, keep it
          quo_q <= {quo_q[kal_num_pkg::DATA_W-2:0], 1'b1};
        end else begin
          rem_q <= trial[kal_num_pkg::DATA_W-1:0];  // restore
          quo_q <= {quo_q[kal_num_pkg::DATA_W-2:0], 1'b0};
        end
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == kal_num_pkg::DIV_CNT_W'(1)) begin
          busy_q <= 1'b0;  // last bit lands this edge
          done_q <= 1'b1;
        end
      end
    end
  end

  assign o_done     = done_q;
  assign o_quotient = quo_q;  // stable from done until the next start

  // zero divisor would give all-ones quotient and a bogus gain
  a_div_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> (i_divisor != '0))
    else $error("divider started with zero divisor");

endmodule

// ==== kal_multiplier.sv ====
`timescale 1ns/1ns

module kal_multiplier (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,
  input  logic signed [kal_num_pkg::DATA_W-1:0] i_a,
  input  logic signed [kal_num_pkg::DATA_W-1:0] i_b,
  output logic signed [kal_num_pkg::PROD_W-1:0] o_p
);

  logic signed [kal_num_pkg::DATA_W-1:0] a_q;  // stage 1 operands
  logic signed [kal_num_pkg::DATA_W-1:0] b_q;
  logic signed [kal_num_pkg::PROD_W-1:0] p_q;  // stage 2 product

  // new operands every cycle, result two edges later
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      a_q <= '0;
      b_q <= '0;
      p_q <= '0;
    end else begin
      a_q <= i_a;
      b_q <= i_b;
      p_q <= a_q * b_q;  // full 64-bit signed product
    end
  end

  assign o_p = p_q;

endmodule

// ==== kal_meas_queue.sv ====
`timescale 1ns/1ns

module kal_meas_queue (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_push,
  input  kal_ctrl_pkg::kal_meas_t i_data,
  input  logic                   i_pop,
  output kal_ctrl_pkg::kal_meas_t o_head,
  output logic                   o_not_empty,
  output logic                   o_credit
);

  kal_ctrl_pkg::kal_meas_t mem [kal_num_pkg::MEAS_QUEUE_DEPTH];  // sample storage

  logic [kal_num_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [kal_num_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [kal_num_pkg::QUEUE_CNT_W-1:0] count_q;  // occupancy
  logic                                credit_q;
  logic                                full;
  logic                                do_push;
  logic                                do_pop;

  assign full    = (count_q == kal_num_pkg::QUEUE_CNT_W'(kal_num_pkg::MEAS_QUEUE_DEPTH));
  assign do_push = i_push && !full;         // overflow dropped, assertion below fires
  assign do_pop  = i_pop && (count_q != '0);

  always_ff @(posedge i_clk) begin
    if (do_push) mem[wr_ptr_q] <= i_data;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two, wraps
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
      credit_q <= do_pop;  // one credit back per freed entry
    end
  end

  assign o_head      = mem[rd_ptr_q];
  assign o_not_empty = (count_q != '0);
  assign o_credit    = credit_q;

  // sender pushed without a credit
  a_credit_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_push |-> !full)
    else $error("credit violation, push into full measurement queue");

  a_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> o_not_empty)
    else $error("pop from empty measurement queue");

endmodule

// ==== kal_filter_core.sv ====
`timescale 1ns/1ns

module kal_filter_core (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  kal_ctrl_pkg::kal_cfg_t  i_cfg,
  input  kal_ctrl_pkg::kal_meas_t i_meas,
  input  logic                    i_meas_ready,
  output logic                    o_pop,
  output logic                    o_est_valid,
  output kal_ctrl_pkg::kal_est_t  o_est
);

  kal_ctrl_pkg::kal_state_e state_q;
  kal_ctrl_pkg::kal_est_t   est_q;    // last posterior and the output register
  logic                     valid_q;
  logic                     wait_q;   // second cycle of UPDATE_WAIT

  logic signed [kal_num_pkg::DATA_W-1:0] meas_ext;
  logic signed [kal_num_pkg::DATA_W-1:0] meas_q;    // sign-extended sample
  logic signed [kal_num_pkg::DATA_W-1:0] x_pre_q;   // prior state
  logic signed [kal_num_pkg::DATA_W-1:0] p_pre_q;   // prior variance
  logic signed [kal_num_pkg::DATA_W-1:0] innov_q;   // z - x_prior
  logic signed [kal_num_pkg::DATA_W-1:0] gain_q;    // k in Q13
  logic signed [kal_num_pkg::DATA_W-1:0] gain_c_q;  // 1 - k in Q13
  logic signed [kal_num_pkg::DATA_W-1:0] p_prior;
  logic signed [kal_num_pkg::DATA_W-1:0] p_plus_r;

  logic                                  div_start;
  logic                                  div_done;
  logic [kal_num_pkg::DATA_W-1:0]        div_dividend;
  logic [kal_num_pkg::DATA_W-1:0]        div_divisor;
  logic [kal_num_pkg::DATA_W-1:0]        div_quot;
  logic signed [kal_num_pkg::PROD_W-1:0] prod_x;    // k * innovation
  logic signed [kal_num_pkg::PROD_W-1:0] prod_p;    // (1 - k) * p_prior

  assign meas_ext = {{(kal_num_pkg::DATA_W - kal_num_pkg::MEAS_W){i_meas.z[kal_num_pkg::MEAS_W-1]}},
                     i_meas.z};

  // predict terms only mean something in PREDICT where cfg is sampled
  assign p_prior  = est_q.p + $signed(i_cfg.q);
  assign p_plus_r = p_prior + $signed(i_cfg.r);

  assign o_pop        = (state_q == kal_ctrl_pkg::IDLE) && i_meas_ready;
  assign div_start    = (state_q == kal_ctrl_pkg::PREDICT);  // divider loads at end of PREDICT
  assign div_dividend = p_prior << kal_num_pkg::FRAC_BITS;   // p_prior in Q13
  assign div_divisor  = p_plus_r;

  kal_divider u_div (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (div_start),
    .i_dividend (div_dividend),
    .i_divisor  (div_divisor),
    .o_done     (div_done),
    .o_quotient (div_quot)
  );

  // operands stay put from done through UPDATE so the product is ready in UPDATE
  kal_multiplier u_mult_x (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_a     (gain_q),
    .i_b     (innov_q),
    .o_p     (prod_x)
  );

  kal_multiplier u_mult_p (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_a     (gain_c_q),
    .i_b     (p_pre_q),
    .o_p     (prod_p)
  );

  // datapath registers
  always_ff @(posedge i_clk) begin
    if (o_pop) meas_q <= meas_ext;  // latch head with the pop
    if (state_q == kal_ctrl_pkg::PREDICT) begin
      x_pre_q <= est_q.x;  // prior state is last estimate
      p_pre_q <= p_prior;
      innov_q <= meas_q - est_q.x;
    end
    if (div_done) begin
      gain_q   <= $signed(div_quot);
      gain_c_q <= kal_num_pkg::ONE_Q13 - $signed(div_quot);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= kal_ctrl_pkg::IDLE;
      wait_q  <= 1'b0;
      valid_q <= 1'b0;
      est_q.x <= '0;
      est_q.p <= kal_num_pkg::P_INIT;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        kal_ctrl_pkg::IDLE:    if (o_pop) state_q <= kal_ctrl_pkg::PREDICT;
        kal_ctrl_pkg::PREDICT: state_q <= kal_ctrl_pkg::GAIN;
        kal_ctrl_pkg::GAIN:    if (div_done) state_q <= kal_ctrl_pkg::UPDATE_WAIT;
        kal_ctrl_pkg::UPDATE_WAIT: begin
          wait_q <= !wait_q;  // two cycles for the mult pipe
          if (wait_q) state_q <= kal_ctrl_pkg::UPDATE;
        end
        kal_ctrl_pkg::UPDATE: begin
          est_q.x <= x_pre_q + prod_x[kal_num_pkg::FRAC_BITS +: kal_num_pkg::DATA_W];  // >>> 13
          est_q.p <= prod_p[kal_num_pkg::FRAC_BITS +: kal_num_pkg::DATA_W];
          valid_q <= 1'b1;
          state_q <= kal_ctrl_pkg::IDLE;
        end
        default: state_q <= kal_ctrl_pkg::IDLE;
      endcase
    end
  end

  assign o_est_valid = valid_q;
  assign o_est       = est_q;

  // p + Q + R must stay positive or the gain is garbage
  a_divisor_pos: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (state_q == kal_ctrl_pkg::PREDICT) |-> (p_plus_r > 0))
    else $error("gain divisor not positive in PREDICT");

endmodule

// ==== kalman_top.sv ====
`timescale 1ns/1ns

module kalman_top (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  kal_ctrl_pkg::kal_cfg_t  i_cfg,
  input  logic                    i_meas_valid,
  input  kal_ctrl_pkg::kal_meas_t i_meas,
  output logic                    o_meas_credit,
  output logic                    o_est_valid,
  output kal_ctrl_pkg::kal_est_t  o_est
);

  kal_ctrl_pkg::kal_meas_t q_head;       // oldest queued sample
  logic                    q_not_empty;
  logic                    core_pop;     // core takes the head

  // credit-managed input buffer
  kal_meas_queue u_queue (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_push      (i_meas_valid),
    .i_data      (i_meas),
    .i_pop       (core_pop),
    .o_head      (q_head),
    .o_not_empty (q_not_empty),
    .o_credit    (o_meas_credit)
  );

  kal_filter_core u_core (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cfg        (i_cfg),
    .i_meas       (q_head),
    .i_meas_ready (q_not_empty),
    .o_pop        (core_pop),
    .o_est_valid  (o_est_valid),
    .o_est        (o_est)
  );

endmodule

// ==== tb_kalman_top.sv ====
`timescale 1ns/1ns

module tb_kalman_top;

  localparam int     DEPTH      = kal_num_pkg::MEAS_QUEUE_DEPTH;
  localparam longint ONE        = longint'(kal_num_pkg::ONE_Q13);  // 1.0 in Q13
  localparam int     WAIT_LIMIT = 200;  // cycles allowed per wait loop

  logic                    clk;
  logic                    rst_n;
  logic                    meas_valid;
  logic                    meas_credit;
  logic                    est_valid;
  kal_ctrl_pkg::kal_cfg_t  cfg;
  kal_ctrl_pkg::kal_meas_t meas;
  kal_ctrl_pkg::kal_est_t  est;

  int     errors;
  int     tests_run;
  int     tests_failed;
  int     test_err_start;   // error count when the current test began
  int     credits_used;     // beats sent
  int     credit_pulses;    // credits handed back by the DUT
  int     checked;          // estimates already compared
  integer seed;
  longint mx;               // model state
  longint mp;               // model variance
  longint mq;
  longint mr;
  longint exp_x[$];
  longint exp_p[$];
  longint got_x[$];
  longint got_p[$];

  kalman_top u_kalman_top (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_cfg         (cfg),
    .i_meas_valid  (meas_valid),
    .i_meas        (meas),
    .o_meas_credit (meas_credit),
    .o_est_valid   (est_valid),
    .o_est         (est)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (meas_credit) credit_pulses = credit_pulses + 1;
      if (est_valid) begin
        got_x.push_back(longint'(est.x));
        got_p.push_back(longint'(est.p));
      end
    end
  end

  function automatic longint floor_div(input longint n, input longint d);
    longint qt;
    qt = n / d;  // truncates toward zero
    if ((n % d != 0) && ((n < 0) != (d < 0))) qt = qt - 1;
    return qt;
  endfunction

  function automatic int credits_avail();
    return DEPTH - credits_used + credit_pulses;
  endfunction

  // one filter step on the model queues the expected result
  task automatic model_step(input int z);
    longint p_pri;
    longint k;
    p_pri = mp + mq;                                  // predict
    k     = floor_div(p_pri * ONE, p_pri + mr);       // gain in Q13
    mx    = mx + floor_div(k * (longint'(z) - mx), ONE);
    mp    = floor_div((ONE - k) * p_pri, ONE);
    exp_x.push_back(mx);
    exp_p.push_back(mp);
  endtask

  task automatic compare(input longint got, input longint expv, input string msg);
    if (got !== expv) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, msg, got, expv);
    end
  endtask

  task automatic set_cfg(input longint q, input longint r);
    @(posedge clk);
    #10;
    cfg.q = 32'(q);
    cfg.r = 32'(r);
    mq    = q;
    mr    = r;
  endtask

  // one beat with valid left high for the next call
  task automatic send_meas(input int z);
    int n;
    n = 0;
    @(posedge clk);
    #10;
    while (credits_avail() == 0 && n < WAIT_LIMIT) begin
      meas_valid = 1'b0;  // hold off while out of credit
      @(posedge clk);
      #10;
      n++;
    end
    if (credits_avail() == 0) begin
      errors++;
      $display("Error at %0t ns: no credit came back within %0d cycles", $time, WAIT_LIMIT);
    end else begin
      meas_valid = 1'b1;
      meas.z     = 14'(z);
      credits_used++;
      model_step(z);
    end
  endtask

  task automatic end_burst();
    @(posedge clk);
    #10;
    meas_valid = 1'b0;
  endtask

  // block until every expected estimate showed up and compare them in order
  task automatic check_estimates();
    int n;
    n = 0;
    while (got_x.size() < exp_x.size() && n < WAIT_LIMIT * (exp_x.size() - checked)) begin
      @(posedge clk);
      n++;
    end
    if (got_x.size() < exp_x.size()) begin
      errors++;
      $display("Error at %0t ns: waited too long for estimate valid, got %0d of %0d",
               $time, got_x.size(), exp_x.size());
    end
    while (checked < got_x.size() && checked < exp_x.size()) begin
      compare(got_x[checked], exp_x[checked], $sformatf("estimate %0d x", checked));
      compare(got_p[checked], exp_p[checked], $sformatf("estimate %0d p", checked));
      checked++;
    end
    repeat (3) @(posedge clk);  // no stray pulses after the last one
    compare(longint'(got_x.size()), longint'(exp_x.size()), "estimate count");
    compare(longint'(credits_avail()), longint'(DEPTH), "credits held after drain");
  endtask

  task automatic start_test();
    test_err_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s FAILED, %0d errors", name, errors - test_err_start);
    end
  endtask

  task automatic after_reset();
    start_test();
    repeat (4) @(posedge clk);
    #10;
    compare(longint'(est_valid), 0, "valid after reset");
    compare(longint'(est.x), 0, "x after reset");
    compare(longint'(est.p), longint'(kal_num_pkg::P_INIT), "p after reset");
    compare(longint'(credit_pulses), 0, "credit pulses after reset");
    finish_test("reset");
  endtask

  task automatic single_sample();
    start_test();
    send_meas(1500);
    end_burst();
    check_estimates();
    compare(longint'(credit_pulses), longint'(credits_used), "credits returned");
    finish_test("single");
  endtask

  task automatic negative_samples();
    start_test();
    send_meas(-8192);  // 14-bit minimum
    send_meas(-8191);
    send_meas(-7000);
    end_burst();
    check_estimates();
    finish_test("negative");
  endtask

  task automatic full_burst();
    start_test();
    compare(longint'(credits_avail()), longint'(DEPTH), "credits before burst");
    for (int i = 0; i < DEPTH; i++) begin
      send_meas((i % 2 == 0) ? 600 * i + 300 : -450 * i);
    end
    end_burst();
    check_estimates();
    finish_test("burst");
  endtask

  task automatic random_stream();
    int z;
    start_test();
    for (int i = 0; i < 30; i++) begin
      z = $random(seed) % 8192;  // stays inside 14 bits
      send_meas(z);
    end
    end_burst();
    check_estimates();
    finish_test("random");
  endtask

  task automatic cfg_change();
    start_test();
    set_cfg(20000, 3000);  // high Q and low R
    send_meas(4000);
    end_burst();
    check_estimates();
    set_cfg(500, 80000);   // trust the model more
    send_meas(-3000);
    end_burst();
    check_estimates();
    finish_test("cfg_change");
  endtask

  initial begin
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    credits_used  = 0;
    credit_pulses = 0;
    checked       = 0;
    seed          = 72;
    mx            = 0;
    mp            = longint'(kal_num_pkg::P_INIT);
    mq            = 1000;
    mr            = 50000;
    rst_n         = 1'b0;
    meas_valid    = 1'b0;
    meas          = '0;
    cfg.q         = 32'(mq);
    cfg.r         = 32'(mr);
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;

    after_reset();
    single_sample();
    negative_samples();
    full_burst();
    random_stream();
    cfg_change();

    $display("tests %0d, failed %0d, errors %0d, estimates %0d",
             tests_run, tests_failed, errors, checked);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
kal_num_pkg.sv
kal_ctrl_pkg.sv
kal_divider.sv
kal_multiplier.sv
kal_meas_queue.sv
kal_filter_core.sv
kalman_top.sv
tb_kalman_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_kalman_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
